// File: hacd_cfg.svh
// managed region is HACD_LINES lines starting at HACD_BASE_ADDR
// base address must be aligned to a 16-byte line
`ifndef HACD_CFG_SVH
`define HACD_CFG_SVH

// lines in the zero-tracked region
`define HACD_LINES 64

// word and line geometry
`define HACD_WORD_W 32
`define HACD_LINE_WORDS 4

// byte address of line 0
`define HACD_BASE_ADDR 32'h8000_0000

`endif

// File: hacd_data_pkg.sv
// widths follow hacd_cfg.svh; address bus fixed at 32 bits
`include "hacd_cfg.svh"

package hacd_data_pkg;

   ////////////////////////////////////////
   // geometry
   ////////////////////////////////////////
   localparam int addr_w = 32;
   localparam int word_w = `HACD_WORD_W;
   localparam int line_words = `HACD_LINE_WORDS;
   localparam int line_w = word_w * line_words;
   localparam int line_bytes = line_w / 8;
   // byte offset bits inside one line
   localparam int ofs_w = $clog2(line_bytes);
   localparam int idx_w = $clog2(`HACD_LINES);

   ////////////////////////////////////////
   // vector types
   ////////////////////////////////////////
   typedef logic [addr_w-1:0] addr_t;
   typedef logic [word_w-1:0] word_t;
   typedef logic [line_w-1:0] line_t;
   typedef logic [idx_w-1:0]  line_idx_t;

endpackage

// File: hacd_ctrl_pkg.sv
// opcode and FSM encodings shared by decode and execute

package hacd_ctrl_pkg;

   // decoded request class
   typedef enum logic [1:0] {
      op_rd      = 2'd0,
      op_wr_zero = 2'd1,
      op_wr_data = 2'd2,
      op_bad     = 2'd3
   } op_t;

   // execute stage FSM
   typedef enum logic [1:0] {
      st_idle     = 2'd0,
      st_mem_req  = 2'd1,
      st_mem_wait = 2'd2,
      st_done     = 2'd3
   } exec_state_t;

endpackage

// File: hacd_if.sv
// valid/ready links between pipeline stages; no clock inside
// src holds valid and fields stable until ready
`timescale 1ns/100ps

////////////////////////////////////////
// decode -> execute
////////////////////////////////////////
interface hacd_op_if;
   logic                     valid;
   logic                     ready;
   hacd_ctrl_pkg::op_t       op;
   hacd_data_pkg::line_idx_t idx;
   hacd_data_pkg::addr_t     addr;
   hacd_data_pkg::line_t     data;

   modport src (output valid, op, idx, addr, data, input ready);
   modport snk (input valid, op, idx, addr, data, output ready);
endinterface

////////////////////////////////////////
// execute -> result
////////////////////////////////////////
interface hacd_rsp_if;
   logic                 valid;
   logic                 ready;
   hacd_data_pkg::line_t data;
   logic                 err;
   // write ack, data is don't care
   logic                 write;

   modport src (output valid, data, err, write, input ready);
   modport snk (input valid, data, err, write, output ready);
endinterface

// File: hacd_req_decode.sv
// one-entry request register; only line aligned addresses are accepted
// anything outside the region or misaligned becomes op_bad
`timescale 1ns/100ps
`include "hacd_cfg.svh"

module hacd_req_decode (
   input  logic                 clk,
   input  logic                 rst_n,
   input  logic                 req_valid,
   output logic                 req_ready,
   input  logic                 req_write,
   input  hacd_data_pkg::addr_t req_addr,
   input  hacd_data_pkg::line_t req_data,
   hacd_op_if.src               op
);
   import hacd_data_pkg::*;
   import hacd_ctrl_pkg::*;

   localparam addr_t region_bytes = addr_t'(`HACD_LINES * line_bytes);

   addr_t offset;
   word_t cur_word;
   logic  all_zero;
   logic  in_range;
   logic  aligned;
   logic  accept;
   op_t   op_d;

   // free slot or slot drains this cycle
   assign req_ready = !op.valid || op.ready;
   assign accept = req_valid && req_ready;

   ////////////////////////////////////////
   // classify
   ////////////////////////////////////////
   // below-base addresses wrap to a large offset
   assign offset = req_addr - addr_t'(`HACD_BASE_ADDR);
   assign in_range = offset < region_bytes;
   assign aligned = req_addr[ofs_w-1:0] == '0;

   always_comb begin
      all_zero = 1'b1;
      cur_word = '0;
      for (int w = 0; w < line_words; w++) begin
         cur_word = req_data[w*word_w +: word_w];
         if (cur_word != '0) begin
            all_zero = 1'b0;
         end
      end
   end

   always_comb begin
      if (!in_range || !aligned) begin
         op_d = op_bad;
      end else if (!req_write) begin
         op_d = op_rd;
      end else if (all_zero) begin
         op_d = op_wr_zero;
      end else begin
         op_d = op_wr_data;
      end
   end

   ////////////////////////////////////////
   // request register
   ////////////////////////////////////////
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         op.valid <= 1'b0;
      end else if (accept) begin
         op.valid <= 1'b1;
      end else if (op.ready) begin
         op.valid <= 1'b0;
      end
   end

   always_ff @(posedge clk) begin
      if (accept) begin
         op.op   <= op_d;
         op.idx  <= offset[ofs_w +: idx_w];
         op.addr <= req_addr;
         op.data <= req_data;
      end
   end

   // stalled item must not change under execute
   a_op_hold : assert property (@(posedge clk) disable iff (!rst_n)
      op.valid && !op.ready |=> op.valid && $stable(op.op) && $stable(op.idx)
         && $stable(op.addr) && $stable(op.data));

endmodule

// File: hacd_line_exec.sv
// zero-line table resets to all ones, so the region starts out reading zero
// one memory transaction at a time; memory must answer in order, no mem_resp ready
`timescale 1ns/100ps
`include "hacd_cfg.svh"

module hacd_line_exec (
   input  logic                 clk,
   input  logic                 rst_n,
   hacd_op_if.snk               op,
   hacd_rsp_if.src              rsp,
   output logic                 mem_req_valid,
   input  logic                 mem_req_ready,
   output logic                 mem_req_write,
   output hacd_data_pkg::addr_t mem_req_addr,
   output hacd_data_pkg::line_t mem_req_data,
   input  logic                 mem_resp_valid,
   input  hacd_data_pkg::line_t mem_resp_data
);
   import hacd_data_pkg::*;
   import hacd_ctrl_pkg::*;

   exec_state_t            state_q;
   exec_state_t            state_d;
   logic [`HACD_LINES-1:0] zero_tbl_q;
   addr_t                  item_addr_q;
   line_t                  item_data_q;
   line_t                  rsp_data_q;
   logic                   rsp_err_q;
   logic                   rsp_write_q;
   logic                   accept;
   logic                   need_mem;

   // next item may enter while the finished one leaves
   assign op.ready = (state_q == st_idle) || (state_q == st_done && rsp.ready);
   assign accept = op.valid && op.ready;

   // nonzero write, or read of a line that holds data
   assign need_mem = (op.op == op_wr_data) || (op.op == op_rd && !zero_tbl_q[op.idx]);

   ////////////////////////////////////////
   // FSM
   ////////////////////////////////////////
   always_comb begin
      state_d = state_q;
      case (state_q)
         st_idle: begin
            if (op.valid) begin
               state_d = need_mem ? st_mem_req : st_done;
            end
         end
         st_mem_req: begin
            if (mem_req_ready) begin
               state_d = st_mem_wait;
            end
         end
         st_mem_wait: begin
            if (mem_resp_valid) begin
               state_d = st_done;
            end
         end
         st_done: begin
            if (rsp.ready) begin
               if (op.valid) begin
                  state_d = need_mem ? st_mem_req : st_done;
               end else begin
                  state_d = st_idle;
               end
            end
         end
         default: state_d = st_idle;
      endcase
   end

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         state_q <= st_idle;
      end else begin
         state_q <= state_d;
      end
   end

   // updated on accept so the next item already sees it
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         zero_tbl_q <= '1;
      end else if (accept) begin
         if (op.op == op_wr_zero) begin
            zero_tbl_q[op.idx] <= 1'b1;
         end else if (op.op == op_wr_data) begin
            zero_tbl_q[op.idx] <= 1'b0;
         end
      end
   end

   ////////////////////////////////////////
   // item and response payload
   ////////////////////////////////////////
   always_ff @(posedge clk) begin
      if (accept) begin
         item_addr_q <= op.addr;
         item_data_q <= op.data;
         rsp_write_q <= (op.op == op_wr_zero) || (op.op == op_wr_data);
         rsp_err_q   <= op.op == op_bad;
         rsp_data_q  <= '0;
      end else if (state_q == st_mem_wait && mem_resp_valid) begin
         rsp_data_q <= mem_resp_data;
      end
   end

   assign mem_req_valid = state_q == st_mem_req;
   assign mem_req_write = rsp_write_q;
   assign mem_req_addr = item_addr_q;
   assign mem_req_data = item_data_q;

   assign rsp.valid = state_q == st_done;
   assign rsp.data = rsp_data_q;
   assign rsp.err = rsp_err_q;
   assign rsp.write = rsp_write_q;

   // memory answers only the request it was given
   a_mem_resp_wait : assert property (@(posedge clk) disable iff (!rst_n)
      mem_resp_valid |-> state_q == st_mem_wait);

endmodule

// File: hacd_resp_result.sv
// single response register toward the CPU; write acks return zero data
`timescale 1ns/100ps

module hacd_resp_result (
   input  logic                 clk,
   input  logic                 rst_n,
   hacd_rsp_if.snk              rsp,
   output logic                 cpu_resp_valid,
   input  logic                 cpu_resp_ready,
   output hacd_data_pkg::line_t cpu_resp_data,
   output logic                 cpu_resp_err
);

   logic capture;

   // empty, or the CPU takes the current one now
   assign rsp.ready = !cpu_resp_valid || cpu_resp_ready;
   assign capture = rsp.valid && rsp.ready;

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         cpu_resp_valid <= 1'b0;
      end else if (capture) begin
         cpu_resp_valid <= 1'b1;
      end else if (cpu_resp_ready) begin
         cpu_resp_valid <= 1'b0;
      end
   end

   always_ff @(posedge clk) begin
      if (capture) begin
         // memory write acks carry junk data
         cpu_resp_data <= rsp.write ? '0 : rsp.data;
         cpu_resp_err  <= rsp.err;
      end
   end

   ////////////////////////////////////////
   // back-pressure check
   ////////////////////////////////////////
   a_resp_hold : assert property (@(posedge clk) disable iff (!rst_n)
      cpu_resp_valid && !cpu_resp_ready |=> cpu_resp_valid && $stable(cpu_resp_data)
         && $stable(cpu_resp_err));

endmodule

// File: hacd_core.sv
// three-stage front end: decode, execute, result; one item per stage
// every CPU request gets exactly one response, in order
`timescale 1ns/100ps

module hacd_core (
   input  logic                 clk,
   input  logic                 rst_n,

   // cpu request and response
   input  logic                 cpu_req_valid,
   output logic                 cpu_req_ready,
   input  logic                 cpu_req_write,
   input  hacd_data_pkg::addr_t cpu_req_addr,
   input  hacd_data_pkg::line_t cpu_req_data,
   output logic                 cpu_resp_valid,
   input  logic                 cpu_resp_ready,
   output hacd_data_pkg::line_t cpu_resp_data,
   output logic                 cpu_resp_err,

   // memory controller side
   output logic                 mem_req_valid,
   input  logic                 mem_req_ready,
   output logic                 mem_req_write,
   output hacd_data_pkg::addr_t mem_req_addr,
   output hacd_data_pkg::line_t mem_req_data,
   input  logic                 mem_resp_valid,
   input  hacd_data_pkg::line_t mem_resp_data
);

   hacd_op_if  op_if ();
   hacd_rsp_if rsp_if ();

   hacd_req_decode u_req_decode (
      .clk       (clk),
      .rst_n     (rst_n),
      .req_valid (cpu_req_valid),
      .req_ready (cpu_req_ready),
      .req_write (cpu_req_write),
      .req_addr  (cpu_req_addr),
      .req_data  (cpu_req_data),
      .op        (op_if.src)
   );

   hacd_line_exec u_line_exec (
      .clk            (clk),
      .rst_n          (rst_n),
      .op             (op_if.snk),
      .rsp            (rsp_if.src),
      .mem_req_valid  (mem_req_valid),
      .mem_req_ready  (mem_req_ready),
      .mem_req_write  (mem_req_write),
      .mem_req_addr   (mem_req_addr),
      .mem_req_data   (mem_req_data),
      .mem_resp_valid (mem_resp_valid),
      .mem_resp_data  (mem_resp_data)
   );

   hacd_resp_result u_resp_result (
      .clk            (clk),
      .rst_n          (rst_n),
      .rsp            (rsp_if.snk),
      .cpu_resp_valid (cpu_resp_valid),
      .cpu_resp_ready (cpu_resp_ready),
      .cpu_resp_data  (cpu_resp_data),
      .cpu_resp_err   (cpu_resp_err)
   );

endmodule

// File: tb_hacd_core.sv
// self-checking testbench; one request in flight, random CPU and memory stalls
// memory model answers one request at a time, after 1 to 4 cycles
`timescale 1ns/100ps
`include "hacd_cfg.svh"

module tb_hacd_core;
   import hacd_data_pkg::*;

   localparam int n_entries = 17;
   localparam int bytes_per_line = `HACD_LINE_WORDS * `HACD_WORD_W / 8;
   localparam addr_t base = `HACD_BASE_ADDR;
   localparam addr_t region = addr_t'(`HACD_LINES * bytes_per_line);
   localparam line_t pat_a = 128'h0123_4567_89ab_cdef_0f1e_2d3c_4b5a_6978;
   localparam line_t pat_b = 128'h0000_0000_0000_0000_0000_0000_0000_0001;
   localparam line_t pat_c = 128'hdead_0000_0000_0000_0000_0000_0000_0000;

   typedef struct {
      logic  write;
      addr_t addr;
      line_t data;
      line_t exp_data;
      logic  exp_err;
   } entry_t;

   logic  clk;
   logic  rst_n;
   logic  cpu_req_valid;
   logic  cpu_req_ready;
   logic  cpu_req_write;
   addr_t cpu_req_addr;
   line_t cpu_req_data;
   logic  cpu_resp_valid;
   logic  cpu_resp_ready;
   line_t cpu_resp_data;
   logic  cpu_resp_err;
   logic  mem_req_valid;
   logic  mem_req_ready;
   logic  mem_req_write;
   addr_t mem_req_addr;
   line_t mem_req_data;
   logic  mem_resp_valid;
   line_t mem_resp_data;

   entry_t                 tbl [n_entries];
   line_t                  mem_img [`HACD_LINES];
   logic [`HACD_LINES-1:0] ref_zero;
   int                     mem_req_cnt = 0;
   // request of the entry now in flight
   addr_t                  cur_addr;
   logic                   cur_write;

   hacd_core dut (.*);

   initial clk = 1'b0;
   always #10 clk = ~clk;

   task automatic fail_run(input string msg);
      $display("%s", msg);
      $display("** FAIL **");
      $fatal(1, "run stopped at the first error");
   endtask

   function automatic int line_of(input addr_t a);
      return int'((a - base) / bytes_per_line);
   endfunction

   function automatic void set_entry(input int i, input logic w, input addr_t a,
      input line_t d, input line_t exp, input logic err);
      tbl[i].write = w;
      tbl[i].addr = a;
      tbl[i].data = d;
      tbl[i].exp_data = exp;
      tbl[i].exp_err = err;
   endfunction

   ////////////////////////////////////////
   // cpu side handshakes
   ////////////////////////////////////////
   // called 2 ns after a rising edge
   task automatic send_req(input int i);
      cpu_req_valid = 1'b1;
      cpu_req_write = tbl[i].write;
      cpu_req_addr = tbl[i].addr;
      cpu_req_data = tbl[i].data;
      @(posedge clk);
      while (!cpu_req_ready) @(posedge clk);
      #2;
      cpu_req_valid = 1'b0;
      cpu_resp_ready = $urandom_range(1, 0);
   endtask

   task automatic wait_resp(output line_t data, output logic err);
      @(posedge clk);
      while (!(cpu_resp_valid && cpu_resp_ready)) begin
         #2;
         cpu_resp_ready = $urandom_range(1, 0);
         @(posedge clk);
      end
      data = cpu_resp_data;
      err = cpu_resp_err;
      #2;
      cpu_resp_ready = $urandom_range(1, 0);
   endtask

   ////////////////////////////////////////
   // memory model
   ////////////////////////////////////////
   task automatic run_memory();
      int    wait_cnt;
      int    pend_idx;
      logic  busy;
      logic  pend_write;
      line_t pend_data;
      wait_cnt = 0;
      pend_idx = 0;
      busy = 1'b0;
      pend_write = 1'b0;
      pend_data = '0;
      mem_req_ready = 1'b0;
      mem_resp_valid = 1'b0;
      mem_resp_data = '0;
      forever begin
         @(posedge clk);
         if (rst_n && mem_req_valid && mem_req_ready) begin
            assert (mem_req_addr >= base && mem_req_addr < base + region
               && mem_req_addr[ofs_w-1:0] == '0)
               else fail_run($sformatf("FAILED at %0t ns: memory request to bad address %08h",
                  $time, mem_req_addr));
            assert (mem_req_addr == cur_addr && mem_req_write == cur_write)
               else fail_run($sformatf(
                  "FAILED at %0t ns: memory request %0b/%08h, expected %0b/%08h",
                  $time, mem_req_write, mem_req_addr, cur_write, cur_addr));
            busy = 1'b1;
            pend_write = mem_req_write;
            pend_idx = line_of(mem_req_addr);
            pend_data = mem_req_data;
            wait_cnt = $urandom_range(4, 1);
            mem_req_cnt++;
         end
         #2;
         mem_resp_valid = 1'b0;
         if (busy) begin
            wait_cnt--;
            if (wait_cnt == 0) begin
               mem_resp_valid = 1'b1;
               busy = 1'b0;
               if (pend_write) begin
                  mem_img[pend_idx] = pend_data;
                  // ack data is junk on purpose
                  mem_resp_data = {$urandom, $urandom, $urandom, $urandom};
               end else begin
                  mem_resp_data = mem_img[pend_idx];
               end
            end
         end
         mem_req_ready = !busy && ($urandom_range(3, 0) != 0);
      end
   endtask

   initial begin : watchdog
      #(20 * (n_entries * 200 + 10));
      fail_run($sformatf("timeout: the DUT stopped answering by %0t ns", $time));
   end

   ////////////////////////////////////////
   // main sequence
   ////////////////////////////////////////
   initial begin : main
      line_t got_data;
      logic  got_err;
      logic  bad;
      int    exp_mem;
      int    cnt_before;
      int    idx;
      void'($urandom(32'hdc32_b58d));
      // memory model runs beside the main sequence
      fork
         run_memory();
      join_none
      rst_n = 1'b0;
      cpu_req_valid = 1'b0;
      cpu_req_write = 1'b0;
      cpu_req_addr = '0;
      cpu_req_data = '0;
      cpu_resp_ready = 1'b0;
      cur_addr = '0;
      cur_write = 1'b0;
      ref_zero = '1;
      // fill from the byte address of each word
      for (int l = 0; l < `HACD_LINES; l++) begin
         for (int w = 0; w < `HACD_LINE_WORDS; w++) begin
            mem_img[l][w*`HACD_WORD_W +: `HACD_WORD_W] = base + addr_t'(l*bytes_per_line + w*4);
         end
      end
      set_entry(0, 1'b0, base + 'h000, '0, '0, 1'b0);
      set_entry(1, 1'b1, base + 'h010, pat_a, '0, 1'b0);
      set_entry(2, 1'b0, base + 'h010, '0, pat_a, 1'b0);
      set_entry(3, 1'b1, base + 'h020, pat_b, '0, 1'b0);
      set_entry(4, 1'b1, base + 'h010, '0, '0, 1'b0);
      set_entry(5, 1'b0, base + 'h010, '0, '0, 1'b0);
      set_entry(6, 1'b0, base + 'h020, '0, pat_b, 1'b0);
      set_entry(7, 1'b0, base + region, '0, '0, 1'b1);
      set_entry(8, 1'b0, base - 'h010, '0, '0, 1'b1);
      set_entry(9, 1'b1, base + 'h034, pat_a, '0, 1'b1);
      set_entry(10, 1'b0, base + 'h3f0, '0, '0, 1'b0);
      set_entry(11, 1'b1, base + 'h3f0, pat_c, '0, 1'b0);
      set_entry(12, 1'b0, base + 'h3f0, '0, pat_c, 1'b0);
      set_entry(13, 1'b1, 32'h0000_0040, pat_c, '0, 1'b1);
      set_entry(14, 1'b0, base + 'h028, '0, '0, 1'b1);
      set_entry(15, 1'b1, base + 'h020, '0, '0, 1'b0);
      set_entry(16, 1'b0, base + 'h020, '0, '0, 1'b0);

      repeat (5) @(posedge clk);
      #2;
      rst_n = 1'b1;
      @(posedge clk);
      assert (cpu_req_ready && !cpu_resp_valid && !mem_req_valid)
         else fail_run("handshake outputs are wrong right after reset");
      #2;

      for (int i = 0; i < n_entries; i++) begin
         // expected memory traffic from the zero table rules
         bad = tbl[i].addr < base || tbl[i].addr >= base + region
            || tbl[i].addr[ofs_w-1:0] != '0;
         exp_mem = 0;
         if (!bad) begin
            idx = line_of(tbl[i].addr);
            if (tbl[i].write) begin
               exp_mem = (tbl[i].data != '0) ? 1 : 0;
               ref_zero[idx] = tbl[i].data == '0;
            end else begin
               exp_mem = ref_zero[idx] ? 0 : 1;
            end
         end
         assert (bad == tbl[i].exp_err)
            else fail_run($sformatf("table entry %0d disagrees with the region rules", i));
         cnt_before = mem_req_cnt;
         cur_addr = tbl[i].addr;
         cur_write = tbl[i].write;
         send_req(i);
         wait_resp(got_data, got_err);
         assert (got_err == tbl[i].exp_err)
            else fail_run($sformatf("FAILED at %0t ns: entry %0d err %0b, expected %0b",
               $time, i, got_err, tbl[i].exp_err));
         assert (got_err || got_data == tbl[i].exp_data)
            else fail_run($sformatf("FAILED at %0t ns: entry %0d data %032h, expected %032h",
               $time, i, got_data, tbl[i].exp_data));
         assert (mem_req_cnt - cnt_before == exp_mem)
            else fail_run($sformatf(
               "FAILED at %0t ns: entry %0d made %0d memory requests, expected %0d",
               $time, i, mem_req_cnt - cnt_before, exp_mem));
      end

      repeat (2) @(posedge clk);
      $display("** PASS **");
      $finish;
   end

endmodule

// File: sources.f
+incdir+.
hacd_data_pkg.sv
hacd_ctrl_pkg.sv
hacd_if.sv
hacd_req_decode.sv
hacd_line_exec.sv
hacd_resp_result.sv
hacd_core.sv
tb_hacd_core.sv

// File: Bender.yml
package:
  name: hacd_core

sources:
  - include_dirs:
      - .
    files:
      - hacd_data_pkg.sv
      - hacd_ctrl_pkg.sv
      - hacd_if.sv
      - hacd_req_decode.sv
      - hacd_line_exec.sv
      - hacd_resp_result.sv
      - hacd_core.sv
      - target: test
        files:
          - tb_hacd_core.sv
